/* hdl/core_pkg.sv */
`default_nettype none

package core_pkg;

    // ====================
    // Widths
    // ====================
    localparam int xlen     = 32;
    localparam int num_regs = 32;
    localparam int reg_idx_w = 5;
    localparam int shamt_w  = 5;

    typedef logic [xlen-1:0]      word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;
    typedef logic [31:0]          instr_t;
    typedef logic [6:0]           opcode_t;
    typedef logic [3:0]           alu_op_t;

    // ====================
    // Major opcodes
    // ====================
    localparam opcode_t opc_op     = 7'b0110011;
    localparam opcode_t opc_op_imm = 7'b0010011;
    localparam opcode_t opc_lui    = 7'b0110111;

    // funct3 groups, shared by OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // Selects SUB and SRA/SRAI
    localparam logic [6:0] funct7_alt = 7'b0100000;

    // ====================
    // ALU operations
    // ====================
    localparam alu_op_t alu_add    = 4'd0;
    localparam alu_op_t alu_sub    = 4'd1;
    localparam alu_op_t alu_sll    = 4'd2;
    localparam alu_op_t alu_slt    = 4'd3;
    localparam alu_op_t alu_sltu   = 4'd4;
    localparam alu_op_t alu_xor    = 4'd5;
    localparam alu_op_t alu_srl    = 4'd6;
    localparam alu_op_t alu_sra    = 4'd7;
    localparam alu_op_t alu_or     = 4'd8;
    localparam alu_op_t alu_and    = 4'd9;
    localparam alu_op_t alu_pass_b = 4'd10;

endpackage

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import core_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result
);

    logic [shamt_w-1:0] shamt;

    // Only the low bits of b count for shifts
    assign shamt = b[shamt_w-1:0];

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu:   result = {{(xlen-1){1'b0}}, a < b};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = word_t'($signed(a) >>> shamt);
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            // LUI immediate comes in already shifted
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_valid,
    input  instr_t   instr,
    output reg_idx_t rd1_addr,
    output reg_idx_t rd2_addr,
    input  word_t    rd1_data,
    input  word_t    rd2_data,
    output logic     dx_valid,
    output reg_idx_t dx_rd,
    output reg_idx_t dx_rs1,
    output reg_idx_t dx_rs2,
    output word_t    dx_rs1_data,
    output word_t    dx_rs2_data,
    output word_t    dx_imm,
    output logic     dx_use_imm,
    output alu_op_t  dx_alu_op
);

    // ====================
    // Field split
    // ====================
    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    word_t      imm_i;
    word_t      imm_u;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Register reads go out in the same cycle
    assign rd1_addr = instr[19:15];
    assign rd2_addr = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};

    // ====================
    // Control decode
    // ====================
    logic    known;
    logic    use_imm;
    word_t   imm;
    alu_op_t alu_op;
    logic    alt;

    // SUB only exists in register form; SRAI takes the bit from the immediate
    assign alt = (funct7 == funct7_alt);

    always_comb begin
        known   = 1'b1;
        use_imm = 1'b0;
        imm     = imm_i;
        alu_op  = alu_add;
        case (funct3)
            f3_add_sub: alu_op = (alt && opcode == opc_op) ? alu_sub : alu_add;
            f3_sll:     alu_op = alu_sll;
            f3_slt:     alu_op = alu_slt;
            f3_sltu:    alu_op = alu_sltu;
            f3_xor:     alu_op = alu_xor;
            f3_srl_sra: alu_op = alt ? alu_sra : alu_srl;
            f3_or:      alu_op = alu_or;
            default:    alu_op = alu_and;
        endcase
        case (opcode)
            opc_op:     use_imm = 1'b0;
            opc_op_imm: use_imm = 1'b1;
            opc_lui: begin
                use_imm = 1'b1;
                imm     = imm_u;
                alu_op  = alu_pass_b;
            end
            // Anything else becomes a bubble
            default:    known = 1'b0;
        endcase
    end

    // ====================
    // Decode-to-execute register
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dx_valid <= 1'b0;
        end else begin
            dx_valid <= instr_valid && known;
        end
    end

    always_ff @(posedge clk) begin
        dx_rd       <= rd;
        dx_rs1      <= rd1_addr;
        dx_rs2      <= rd2_addr;
        dx_rs1_data <= rd1_data;
        dx_rs2_data <= rd2_data;
        dx_imm      <= imm;
        dx_use_imm  <= use_imm;
        dx_alu_op   <= alu_op;
    end

    a_dx_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(dx_valid)
    );

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     dx_valid,
    input  reg_idx_t dx_rd,
    input  reg_idx_t dx_rs1,
    input  reg_idx_t dx_rs2,
    input  word_t    dx_rs1_data,
    input  word_t    dx_rs2_data,
    input  word_t    dx_imm,
    input  logic     dx_use_imm,
    input  alu_op_t  dx_alu_op,
    output logic     xr_valid,
    output reg_idx_t xr_rd,
    output word_t    xr_data
);

    word_t op_a;
    word_t rs2_fwd;
    word_t op_b;
    word_t alu_result;

    // ====================
    // Forwarding
    // ====================
    // The instruction just ahead sits in xr; x0 is never forwarded
    function automatic word_t fwd(input reg_idx_t src, input word_t reg_data,
                                  input logic prod_valid, input reg_idx_t prod_rd,
                                  input word_t prod_data);
        word_t sel;
        sel = reg_data;
        if (prod_valid && prod_rd != '0 && prod_rd == src) begin
            sel = prod_data;
        end
        return sel;
    endfunction

    assign op_a    = fwd(dx_rs1, dx_rs1_data, xr_valid, xr_rd, xr_data);
    assign rs2_fwd = fwd(dx_rs2, dx_rs2_data, xr_valid, xr_rd, xr_data);
    assign op_b    = dx_use_imm ? dx_imm : rs2_fwd;

    alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (dx_alu_op),
        .result (alu_result)
    );

    // ====================
    // Execute-to-result register
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            xr_valid <= 1'b0;
        end else begin
            xr_valid <= dx_valid;
        end
    end

    always_ff @(posedge clk) begin
        xr_rd   <= dx_rd;
        xr_data <= alu_result;
    end

    // The forwarding mux trusts xr_valid to be clean
    a_xr_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(xr_valid)
    );

endmodule

`default_nettype wire

/* hdl/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     xr_valid,
    input  reg_idx_t xr_rd,
    input  word_t    xr_data,
    input  reg_idx_t rd1_addr,
    input  reg_idx_t rd2_addr,
    output word_t    rd1_data,
    output word_t    rd2_data,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    word_t regs [num_regs];
    logic  wr_en;

    assign wr_en = xr_valid && (xr_rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[xr_rd] <= xr_data;
        end
    end

    // Read port with write-through for the producer two instructions back
    function automatic word_t rd_port(input reg_idx_t addr);
        word_t val;
        val = regs[addr];
        if (addr == '0) begin
            val = '0;
        end else if (wr_en && xr_rd == addr) begin
            val = xr_data;
        end
        return val;
    endfunction

    always_comb begin
        rd1_data = rd_port(rd1_addr);
        rd2_data = rd_port(rd2_addr);
    end

    // Writeback strobe mirrors the write landing at the coming edge
    assign wb_valid = xr_valid;
    assign wb_rd    = xr_rd;
    assign wb_data  = xr_data;

    a_x0_stays_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (xr_valid && xr_rd == '0) |->
            ((rd1_addr != '0 || rd1_data == '0) && (rd2_addr != '0 || rd2_data == '0))
    );

endmodule

`default_nettype wire

/* hdl/int_pipeline_top.sv */
`timescale 1ns/1ps
`default_nettype none

module int_pipeline_top import core_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     instr_valid,
    input  instr_t   instr,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);

    // ====================
    // Stage links
    // ====================
    reg_idx_t rd1_addr;
    reg_idx_t rd2_addr;
    word_t    rd1_data;
    word_t    rd2_data;

    logic     dx_valid;
    reg_idx_t dx_rd;
    reg_idx_t dx_rs1;
    reg_idx_t dx_rs2;
    word_t    dx_rs1_data;
    word_t    dx_rs2_data;
    word_t    dx_imm;
    logic     dx_use_imm;
    alu_op_t  dx_alu_op;

    logic     xr_valid;
    reg_idx_t xr_rd;
    word_t    xr_data;

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd1_addr    (rd1_addr),
        .rd2_addr    (rd2_addr),
        .rd1_data    (rd1_data),
        .rd2_data    (rd2_data),
        .dx_valid    (dx_valid),
        .dx_rd       (dx_rd),
        .dx_rs1      (dx_rs1),
        .dx_rs2      (dx_rs2),
        .dx_rs1_data (dx_rs1_data),
        .dx_rs2_data (dx_rs2_data),
        .dx_imm      (dx_imm),
        .dx_use_imm  (dx_use_imm),
        .dx_alu_op   (dx_alu_op)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .dx_valid    (dx_valid),
        .dx_rd       (dx_rd),
        .dx_rs1      (dx_rs1),
        .dx_rs2      (dx_rs2),
        .dx_rs1_data (dx_rs1_data),
        .dx_rs2_data (dx_rs2_data),
        .dx_imm      (dx_imm),
        .dx_use_imm  (dx_use_imm),
        .dx_alu_op   (dx_alu_op),
        .xr_valid    (xr_valid),
        .xr_rd       (xr_rd),
        .xr_data     (xr_data)
    );

    // Result stage
    register_file u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .xr_valid (xr_valid),
        .xr_rd    (xr_rd),
        .xr_data  (xr_data),
        .rd1_addr (rd1_addr),
        .rd2_addr (rd2_addr),
        .rd1_data (rd1_data),
        .rd2_data (rd2_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

`default_nettype wire

/* dv/tb_int_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_int_pipeline import core_pkg::*; ();

    localparam int num_patterns  = 31;
    localparam int pat_words     = 3 * num_patterns;
    localparam int drain_timeout = 50;
    localparam logic [31:0] bubble_mark = 32'hff;

    logic     clk;
    logic     rst_n;
    logic     instr_valid;
    instr_t   instr;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    // Three words per pattern for instruction, destination and value
    logic [31:0] pat_mem [0:pat_words-1];
    reg_idx_t    exp_rd[$];
    word_t       exp_data[$];

    int_pipeline_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================
    task automatic stop_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            stop_run();
        end
    endtask

    // One cycle of stimulus, applied just after the rising edge
    task automatic drive_cycle(input logic valid, input instr_t word);
        @(posedge clk);
        #1;
        instr_valid = valid;
        instr       = word;
    endtask

    task automatic run_program(input bit with_gaps);
        int gap;
        for (int p = 0; p < num_patterns; p++) begin
            if (with_gaps) begin
                gap = $urandom_range(0, 2);
                // Idle cycles carry garbage on instr
                repeat (gap) drive_cycle(1'b0, instr_t'($urandom));
            end
            drive_cycle(1'b1, pat_mem[3*p]);
            if (pat_mem[3*p+1] != bubble_mark) begin
                exp_rd.push_back(reg_idx_t'(pat_mem[3*p+1]));
                exp_data.push_back(pat_mem[3*p+2]);
            end
        end
        drive_cycle(1'b0, '0);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_data.size() != 0 && cycles < drain_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_data.size() != 0) begin
            $display("[ERROR] timed out with %0d writebacks still expected", exp_data.size());
            stop_run();
        end
    endtask

    // ====================
    // Scoreboard
    // ====================
    always @(negedge clk) begin
        if (rst_n && $isunknown(wb_valid)) begin
            $display("[ERROR] writeback strobe is unknown after reset");
            stop_run();
        end else if (rst_n && wb_valid) begin
            if (exp_data.size() == 0) begin
                $display("[ERROR] writeback to x%0d with no instruction outstanding", wb_rd);
                stop_run();
            end else begin
                check_value("wb_rd", 32'(wb_rd), 32'(exp_rd.pop_front()));
                check_value("wb_data", wb_data, exp_data.pop_front());
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        void'($urandom(78953));
        $readmemh("dv/alu_patterns.hex", pat_mem);
        for (int i = 0; i < pat_words; i++) begin
            if ($isunknown(pat_mem[i])) begin
                $display("[ERROR] pattern file is shorter than expected");
                stop_run();
            end
        end

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Back-to-back pass for forwarding followed by one with idle gaps
        run_program(1'b0);
        wait_drain();
        run_program(1'b1);
        wait_drain();

        // Nothing may trail the last result
        repeat (8) @(posedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
hdl/core_pkg.sv
hdl/alu.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/register_file.sv
hdl/int_pipeline_top.sv
dv/tb_int_pipeline.sv

/* run.sh */
#!/bin/sh
# Build and run the integer pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_int_pipeline -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "all tests passed"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* dv/alu_patterns.hex */
// instruction  expected rd (ff marks a bubble)  expected value
// registers read before being written in this list are never written
00500093 01 00000005 // addi x1, x0, 5
FFD00113 02 FFFFFFFD // addi x2, x0, -3
002081B3 03 00000002 // add  x3, x1, x2
40208233 04 00000008 // sub  x4, x1, x2
001122B3 05 00000001 // slt  x5, x2, x1
00113333 06 00000000 // sltu x6, x2, x1
0020C3B3 07 FFFFFFF8 // xor  x7, x1, x2
00115433 08 07FFFFFF // srl  x8, x2, x1
401154B3 09 FFFFFFFF // sra  x9, x2, x1
0020E533 0A FFFFFFFD // or   x10, x1, x2
0020F5B3 0B 00000005 // and  x11, x1, x2
00409633 0C 00000500 // sll  x12, x1, x4
FFE12693 0D 00000001 // slti  x13, x2, -2
FFF0B713 0E 00000001 // sltiu x14, x1, -1
FFF0C793 0F FFFFFFFA // xori  x15, x1, -1
0F00E813 10 000000F5 // ori   x16, x1, 0x0f0
7F017893 11 000007F0 // andi  x17, x2, 0x7f0
00411913 12 FFFFFFD0 // slli  x18, x2, 4
01C15993 13 0000000F // srli  x19, x2, 28
40115A13 14 FFFFFFFE // srai  x20, x2, 1
ABCDEAB7 15 ABCDE000 // lui   x21, 0xabcde
FFFA8A93 15 ABCDDFFF // addi  x21, x21, -1
06400B13 16 00000064 // addi  x22, x0, 100
016B0BB3 17 000000C8 // add   x23, x22, x22
416B8C33 18 00000064 // sub   x24, x23, x22
00708013 00 0000000C // addi  x0, x1, 7
00100CB3 19 00000005 // add   x25, x0, x1
00500F8B FF 00000000 // custom-0 opcode, bubble
001F8DB3 1B 00000005 // add   x27, x31, x1
0000AE03 FF 00000000 // lw, bubble
001E3EB3 1D 00000001 // sltu  x29, x28, x1
